// ==== include/qla_params.svh ====
// qla motor channel constants
// axis count, bus widths, address fields, register offsets,
// dac frame layout and safety timing
`ifndef QLA_PARAMS_SVH
`define QLA_PARAMS_SVH

// sizes
`define QLA_NUM_AXES      4
`define QLA_DATA_W        32
`define QLA_ADDR_W        16
`define QLA_CUR_W         16     // current cmd and feedback

// address fields, addr[7:4] channel, addr[3:0] offset
`define QLA_CHAN_MSB      7
`define QLA_CHAN_LSB      4
`define QLA_OFF_MSB       3
`define QLA_OFF_LSB       0
`define QLA_CHAN_BOARD    4'd0   // channel 0 is board level

// channel 0 offsets
`define QLA_OFF_STATUS    4'd0
`define QLA_OFF_CTRL      4'd1

// axis channel offsets
`define QLA_OFF_ADC_DATA  4'd0
`define QLA_OFF_DAC_CTRL  4'd1

// quad dac serial frame, cmd + channel + 16 data bits, msb first
`define QLA_DAC_FRAME_W   24
`define QLA_DAC_CMD       4'b0011  // write and update
`define QLA_SCLK_DIV      2        // sysclk cycles per half sclk

// over-current persistence before trip
`define QLA_SAFETY_COUNT  16

`endif

// ==== hdl/qla_pkg.sv ====
// qla shared types
// register bus words, write request bundle and dac fsm states
`include "qla_params.svh"

package qla_pkg;

    // --------------------------------------------------
    // plain vectors
    // --------------------------------------------------
    typedef logic [`QLA_DATA_W-1:0]   reg_data_t;   // register word
    typedef logic [`QLA_ADDR_W-1:0]   reg_addr_t;   // register address
    typedef logic [`QLA_CUR_W-1:0]    cur_t;        // unsigned current magnitude
    typedef logic [`QLA_NUM_AXES-1:0] axis_mask_t;  // one bit per axis

    // --------------------------------------------------
    // register write request, 49 bits
    // --------------------------------------------------
    typedef struct packed {
        logic      wen;    // one cycle strobe
        reg_addr_t waddr;
        reg_data_t wdata;
    } reg_wr_t;

    // dac controller states
    typedef enum logic [1:0] {
        DAC_IDLE,   // wait for pending axis
        DAC_LOAD,   // capture frame, drop csel
        DAC_SHIFT,  // clock out frame bits
        DAC_GAP     // csel high between frames
    } dac_state_t;

endpackage

// ==== hdl/safety_check.sv ====
// safety_check
// per axis over-current monitor, trips when feedback stays above
// twice the command for a run of cycles, latched until cleared
`timescale 1ns/10ps
`include "qla_params.svh"

module safety_check (
    input  logic           sysclk,
    input  logic           arst_n,
    input  qla_pkg::cur_t  cur_fb,
    input  qla_pkg::cur_t  cur_cmd,
    input  logic           clear,
    output logic           trip
);

    localparam int CNT_W = $clog2(`QLA_SAFETY_COUNT + 1);

    logic [`QLA_CUR_W:0] limit;     // 2 * cmd, one extra bit
    logic                over;
    logic [CNT_W-1:0]    persist;   // consecutive over cycles

    assign limit = {cur_cmd, 1'b0};
    assign over  = {1'b0, cur_fb} > limit;

    // --------------------------------------------------
    // persistence counter and trip latch
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            persist <= '0;
            trip    <= 1'b0;
        end else if (clear) begin
            persist <= '0;              // recount if fault still there
            trip    <= 1'b0;
        end else if (!trip) begin
            if (!over) begin
                persist <= '0;          // any dip restarts
            end else begin
                persist <= persist + 1'b1;
                if (persist == CNT_W'(`QLA_SAFETY_COUNT - 1)) trip <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/board_regs.sv ====
// board_regs
// channel 0 registers: power and amplifier enables, board id and
// trip status readback, one cycle safety clear strobes per axis
`timescale 1ns/10ps
`include "qla_params.svh"

module board_regs (
    input  logic                  sysclk,
    input  logic                  arst_n,
    input  qla_pkg::reg_wr_t      reg_wr,
    input  qla_pkg::reg_addr_t    reg_raddr,
    output qla_pkg::reg_data_t    reg_rdata,
    input  logic [3:0]            board_id,
    input  qla_pkg::axis_mask_t   amp_trip,
    output logic                  pwr_enable,
    output qla_pkg::axis_mask_t   amp_enable_req,
    output qla_pkg::axis_mask_t   safety_clear
);

    import qla_pkg::*;

    logic [3:0] wr_chan;
    logic [3:0] wr_off;
    logic [3:0] rd_off;
    logic       ctrl_wr;     // control word write this cycle
    reg_data_t  status_word;
    reg_data_t  ctrl_word;

    assign wr_chan = reg_wr.waddr[`QLA_CHAN_MSB:`QLA_CHAN_LSB];
    assign wr_off  = reg_wr.waddr[`QLA_OFF_MSB:`QLA_OFF_LSB];
    assign rd_off  = reg_raddr[`QLA_OFF_MSB:`QLA_OFF_LSB];

    assign ctrl_wr = reg_wr.wen && (wr_chan == `QLA_CHAN_BOARD) &&
                     (wr_off == `QLA_OFF_CTRL);

    // --------------------------------------------------
    // control word
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_enable     <= 1'b0;
            amp_enable_req <= '0;
            safety_clear   <= '0;
        end else begin
            safety_clear <= '0;                  // strobe, one cycle only
            if (ctrl_wr) begin
                amp_enable_req <= reg_wr.wdata[3:0];
                pwr_enable     <= reg_wr.wdata[8];
                safety_clear   <= reg_wr.wdata[19:16];  // ones clear those axes
            end
        end
    end

    // --------------------------------------------------
    // readback
    // --------------------------------------------------
    assign status_word = {4'd0, board_id,        // [27:24]
                          4'd0, amp_trip,        // [19:16]
                          7'd0, pwr_enable,      // bit 8
                          4'd0, amp_enable_req}; // [3:0]

    // control reads back just the enable fields
    assign ctrl_word = {23'd0, pwr_enable, 4'd0, amp_enable_req};

    // registered every edge, top level picks by channel
    always_ff @(posedge sysclk) begin
        case (rd_off)
            `QLA_OFF_STATUS: reg_rdata <= status_word;
            `QLA_OFF_CTRL:   reg_rdata <= ctrl_word;
            default:         reg_rdata <= '0;
        endcase
    end

endmodule

// ==== hdl/ctrl_dac.sv ====
// ctrl_dac
// stores the four current commands, reads them back, and shifts each
// pending command out to the quad serial dac, round robin by axis
`timescale 1ns/10ps
`include "qla_params.svh"

module ctrl_dac (
    input  logic                sysclk,
    input  logic                arst_n,
    input  qla_pkg::reg_wr_t    reg_wr,
    input  qla_pkg::reg_addr_t  reg_raddr,
    output qla_pkg::reg_data_t  reg_rdata,
    output qla_pkg::cur_t       cur_cmd [`QLA_NUM_AXES],
    output logic                dac_sclk,
    output logic                dac_mosi,
    output logic                dac_csel
);

    import qla_pkg::*;

    localparam int AXIS_W  = $clog2(`QLA_NUM_AXES);
    localparam int FRAME_W = `QLA_DAC_FRAME_W;
    localparam int BIT_W   = $clog2(FRAME_W);
    localparam int DIV_W   = $clog2(`QLA_SCLK_DIV + 1);

    cur_t               cmd [`QLA_NUM_AXES];  // stored commands
    axis_mask_t         pending;              // axes awaiting a frame
    dac_state_t         state;
    logic [AXIS_W-1:0]  rr_ptr;               // round robin start
    logic [AXIS_W-1:0]  sel;                  // axis being sent
    logic [AXIS_W-1:0]  pick;
    logic               pick_valid;
    logic [FRAME_W-1:0] shreg;
    logic [BIT_W-1:0]   bit_cnt;
    logic [DIV_W-1:0]   div_cnt;              // half sclk timer
    logic               half_done;

    logic [3:0]         wr_chan;
    logic [3:0]         rd_chan;
    logic               wr_hit;
    logic               rd_hit;
    logic [AXIS_W-1:0]  wr_axis;
    logic [AXIS_W-1:0]  rd_axis;

    // --------------------------------------------------
    // register decode, channels 1..4 map to axis 0..3
    // --------------------------------------------------
    assign wr_chan = reg_wr.waddr[`QLA_CHAN_MSB:`QLA_CHAN_LSB];
    assign rd_chan = reg_raddr[`QLA_CHAN_MSB:`QLA_CHAN_LSB];
    assign wr_axis = AXIS_W'(wr_chan - 4'd1);
    assign rd_axis = AXIS_W'(rd_chan - 4'd1);

    assign wr_hit = reg_wr.wen && (wr_chan != `QLA_CHAN_BOARD) &&
                    (wr_chan <= 4'(`QLA_NUM_AXES)) &&
                    (reg_wr.waddr[`QLA_OFF_MSB:`QLA_OFF_LSB] == `QLA_OFF_DAC_CTRL);
    assign rd_hit = (rd_chan != `QLA_CHAN_BOARD) && (rd_chan <= 4'(`QLA_NUM_AXES)) &&
                    (reg_raddr[`QLA_OFF_MSB:`QLA_OFF_LSB] == `QLA_OFF_DAC_CTRL);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                cmd[i] <= '0;
            end
            pending <= '0;
        end else begin
            if (state == DAC_LOAD) pending[sel] <= 1'b0;  // taken by this frame
            if (wr_hit) begin
                cmd[wr_axis]     <= reg_wr.wdata[`QLA_CUR_W-1:0];
                pending[wr_axis] <= 1'b1;  // set wins over same cycle load
            end
        end
    end

    assign cur_cmd = cmd;

    always_ff @(posedge sysclk) begin
        reg_rdata <= rd_hit ? reg_data_t'(cmd[rd_axis]) : '0;  // zero extend
    end

    // nearest pending axis at or after rr_ptr
    always_comb begin
        pick       = rr_ptr;
        pick_valid = 1'b0;
        for (int i = `QLA_NUM_AXES - 1; i >= 0; i--) begin
            if (pending[rr_ptr + AXIS_W'(i)]) begin
                pick       = rr_ptr + AXIS_W'(i);
                pick_valid = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // serial fsm
    // --------------------------------------------------
    assign half_done = (div_cnt == DIV_W'(`QLA_SCLK_DIV - 1));
    assign dac_mosi  = shreg[FRAME_W-1];  // msb first

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= DAC_IDLE;
            rr_ptr   <= '0;
            sel      <= '0;
            shreg    <= '0;
            bit_cnt  <= '0;
            div_cnt  <= '0;
            dac_sclk <= 1'b0;
            dac_csel <= 1'b1;
        end else begin
            case (state)
                DAC_IDLE: begin
                    if (pick_valid) begin
                        sel   <= pick;
                        state <= DAC_LOAD;
                    end
                end
                DAC_LOAD: begin
                    shreg    <= {`QLA_DAC_CMD, 4'(sel), cmd[sel]};
                    rr_ptr   <= sel + 1'b1;  // next search starts past this axis
                    bit_cnt  <= '0;
                    div_cnt  <= '0;
                    dac_csel <= 1'b0;
                    state    <= DAC_SHIFT;
                end
                DAC_SHIFT: begin
                    div_cnt <= half_done ? '0 : div_cnt + 1'b1;
                    if (half_done) begin
                        dac_sclk <= ~dac_sclk;
                        if (dac_sclk) begin             // falling edge, next bit
                            if (bit_cnt == BIT_W'(FRAME_W - 1)) begin
                                dac_csel <= 1'b1;       // frame done
                                state    <= DAC_GAP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                shreg   <= {shreg[FRAME_W-2:0], 1'b0};
                            end
                        end
                    end
                end
                DAC_GAP: begin
                    div_cnt <= half_done ? '0 : div_cnt + 1'b1;
                    if (half_done) state <= DAC_IDLE;
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/qla_axis_top.sv ====
// qla_axis_top
// four axis motor channel registers: board regs, dac controller,
// per axis safety monitors, read mux by channel, amp enable gating
`timescale 1ns/10ps
`include "qla_params.svh"

module qla_axis_top (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  qla_pkg::reg_wr_t     reg_wr,
    input  qla_pkg::reg_addr_t   reg_raddr,
    output qla_pkg::reg_data_t   reg_rdata,
    input  logic [3:0]           board_id,
    input  qla_pkg::cur_t        cur_fb [`QLA_NUM_AXES],
    output logic                 dac_sclk,
    output logic                 dac_mosi,
    output logic                 dac_csel,
    output logic                 pwr_enable,
    output qla_pkg::axis_mask_t  amp_enable
);

    import qla_pkg::*;

    reg_data_t  board_rdata;
    reg_data_t  dac_rdata;
    reg_data_t  fb_rdata;       // feedback readback, registered here
    cur_t       cur_cmd [`QLA_NUM_AXES];
    axis_mask_t amp_trip;
    axis_mask_t safety_clear;
    axis_mask_t amp_enable_req;

    logic [3:0] rd_chan;
    logic [3:0] rd_off;
    logic       rd_axis_ok;     // channel 1..4

    assign rd_chan    = reg_raddr[`QLA_CHAN_MSB:`QLA_CHAN_LSB];
    assign rd_off     = reg_raddr[`QLA_OFF_MSB:`QLA_OFF_LSB];
    assign rd_axis_ok = (rd_chan != `QLA_CHAN_BOARD) && (rd_chan <= 4'(`QLA_NUM_AXES));

    // --------------------------------------------------
    // channel 0
    // --------------------------------------------------
    board_regs u_chan0 (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .reg_wr         (reg_wr),
        .reg_raddr      (reg_raddr),
        .reg_rdata      (board_rdata),
        .board_id       (board_id),
        .amp_trip       (amp_trip),
        .pwr_enable     (pwr_enable),
        .amp_enable_req (amp_enable_req),
        .safety_clear   (safety_clear)
    );

    // --------------------------------------------------
    // dac
    // --------------------------------------------------
    ctrl_dac u_dac (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_wr    (reg_wr),
        .reg_raddr (reg_raddr),
        .reg_rdata (dac_rdata),
        .cur_cmd   (cur_cmd),
        .dac_sclk  (dac_sclk),
        .dac_mosi  (dac_mosi),
        .dac_csel  (dac_csel)
    );

    // fb > 2 * cmd monitor per axis
    for (genvar g = 0; g < `QLA_NUM_AXES; g++) begin : g_safe
        safety_check u_safe (
            .sysclk  (sysclk),
            .arst_n  (arst_n),
            .cur_fb  (cur_fb[g]),
            .cur_cmd (cur_cmd[g]),
            .clear   (safety_clear[g]),
            .trip    (amp_trip[g])
        );
    end

    // --------------------------------------------------
    // read path
    // --------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rd_axis_ok && rd_off == `QLA_OFF_ADC_DATA)
            fb_rdata <= reg_data_t'(cur_fb[2'(rd_chan - 4'd1)]);
        else
            fb_rdata <= '0;
    end

    // blocks already registered, this just picks one
    always_comb begin
        if (rd_chan == `QLA_CHAN_BOARD)
            reg_rdata = board_rdata;
        else if (rd_axis_ok && rd_off == `QLA_OFF_DAC_CTRL)
            reg_rdata = dac_rdata;
        else if (rd_axis_ok && rd_off == `QLA_OFF_ADC_DATA)
            reg_rdata = fb_rdata;
        else
            reg_rdata = '0;         // unmapped
    end

    // amp on only with power, request and no trip
    assign amp_enable = amp_enable_req & ~amp_trip & {`QLA_NUM_AXES{pwr_enable}};

endmodule

// ==== bench/tb_qla.sv ====
// tb_qla
// testbench for qla_axis_top
// register bus tasks, dac serial frame decoder, reference model for
// frames, status and trips, frame checker and watchdog
`timescale 1ns/10ps
`include "qla_params.svh"

module tb_qla;

    import qla_pkg::*;

    localparam int CLK_NS       = 10;
    localparam int FW           = `QLA_DAC_FRAME_W;
    localparam int FRAME_CYCLES = 2 * `QLA_SCLK_DIV * FW + 3 * `QLA_SCLK_DIV; // shift + load + gap
    localparam int TEST_FRAMES  = 14;          // frames plus idle waits rounded up
    localparam int MARGIN       = 4;
    localparam int WATCHDOG_NS  = TEST_FRAMES * FRAME_CYCLES * MARGIN * CLK_NS;

    logic       sysclk;
    logic       arst_n;
    reg_wr_t    reg_wr;
    reg_addr_t  reg_raddr;
    reg_data_t  reg_rdata;
    logic [3:0] board_id;
    cur_t       cur_fb [`QLA_NUM_AXES];
    logic       dac_sclk;
    logic       dac_mosi;
    logic       dac_csel;
    logic       pwr_enable;
    axis_mask_t amp_enable;

    int          seed = 3;
    cur_t        cmd_model [`QLA_NUM_AXES];   // latest value written per axis
    logic [FW-1:0] rx_q [$];                  // decoded frames
    logic [FW-1:0] exp_q [$];                 // frames still owed by the dac
    logic [FW-1:0] rx_shift;
    logic [FW-1:0] rx_frame;
    int          rx_bits = 0;
    int          match_idx;
    int          wait_n;
    axis_mask_t  trip_exp;

    qla_axis_top DUT (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .reg_wr     (reg_wr),
        .reg_raddr  (reg_raddr),
        .reg_rdata  (reg_rdata),
        .board_id   (board_id),
        .cur_fb     (cur_fb),
        .dac_sclk   (dac_sclk),
        .dac_mosi   (dac_mosi),
        .dac_csel   (dac_csel),
        .pwr_enable (pwr_enable),
        .amp_enable (amp_enable)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_NS / 2) sysclk = ~sysclk;
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic [FW-1:0] expected_frame(input int axis, input cur_t value);
        logic [FW-1:0] f;
        f                 = '0;
        f[FW-1 -: 4]      = `QLA_DAC_CMD;    // command nibble on top
        f[FW-5 -: 4]      = 4'(axis);        // dac channel
        f[`QLA_CUR_W-1:0] = value;
        return f;
    endfunction

    function automatic reg_data_t expected_status(input logic [3:0] id, input axis_mask_t trip,
                                                  input logic pwr, input axis_mask_t req);
        reg_data_t s;
        s        = '0;
        s[27:24] = id;
        s[19:16] = trip;
        s[8]     = pwr;
        s[3:0]   = req;
        return s;
    endfunction

    // over when feedback exceeds twice the command
    function automatic logic expected_trip(input cur_t fb, input cur_t cmd);
        return int'(fb) > 2 * int'(cmd);
    endfunction

    function automatic reg_addr_t axis_addr(input int axis, input logic [3:0] off);
        return reg_addr_t'({4'(axis + 1), off});   // channel = axis + 1
    endfunction

    function automatic reg_addr_t board_addr(input logic [3:0] off);
        return reg_addr_t'({`QLA_CHAN_BOARD, off});
    endfunction

    // --------------------------------------------------
    // reporting
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                                $time, name, expected, actual));
        end
    endtask

    // --------------------------------------------------
    // bus tasks drive 1 ns after the edge
    // --------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge sysclk);
            #1;
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge sysclk);
        #1;
        reg_wr.wen   = 1'b1;
        reg_wr.waddr = addr;
        reg_wr.wdata = data;
        @(posedge sysclk);                 // strobe taken here
        #1;
        reg_wr.wen = 1'b0;
    endtask

    // rdata is valid one edge after raddr
    task automatic reg_read_check(input reg_addr_t addr, input reg_data_t expected,
                                  input string name);
        @(posedge sysclk);
        #1;
        reg_raddr = addr;
        @(posedge sysclk);
        #1;
        check_val(name, expected, reg_rdata);
    endtask

    // command write plus expected frame bookkeeping
    task automatic dac_write(input int axis, input cur_t value);
        int idx;
        idx = -1;
        reg_write(axis_addr(axis, `QLA_OFF_DAC_CTRL), reg_data_t'(value));
        cmd_model[axis] = value;
        foreach (exp_q[i]) begin
            if (exp_q[i][`QLA_CUR_W+3:`QLA_CUR_W] == 4'(axis)) begin
                idx = i;
            end
        end
        if (idx >= 0) begin
            exp_q[idx] = expected_frame(axis, value);  // not sent yet so latest wins
        end else begin
            exp_q.push_back(expected_frame(axis, value));
        end
    endtask

    task automatic wait_frames_done();
        while (exp_q.size() != 0) begin
            @(posedge sysclk);                 // watchdog bounds this
        end
        #1;
    endtask

    // --------------------------------------------------
    // dac serial decoder and frame checker
    // --------------------------------------------------
    always @(posedge dac_sclk) begin
        if (!dac_csel) begin
            rx_shift = {rx_shift[FW-2:0], dac_mosi};   // msb first
            rx_bits  = rx_bits + 1;
            if (rx_bits == FW) begin
                rx_q.push_back(rx_shift);
                rx_bits = 0;
            end
        end
    end

    always @(posedge dac_csel) begin
        if (rx_bits != 0) begin
            abort_run($sformatf("dac frame ended after %0d of %0d bits", rx_bits, FW));
        end
    end

    // match by channel field since axis order is not fixed
    always @(negedge sysclk) begin
        if (rx_q.size() != 0) begin
            rx_frame  = rx_q.pop_front();
            match_idx = -1;
            foreach (exp_q[i]) begin
                if (match_idx < 0 &&
                    exp_q[i][`QLA_CUR_W+3:`QLA_CUR_W] == rx_frame[`QLA_CUR_W+3:`QLA_CUR_W]) begin
                    match_idx = i;
                end
            end
            if (match_idx < 0) begin
                abort_run($sformatf("dac sent frame 0x%06h with no write pending", rx_frame));
            end else begin
                check_val("dac_frame", 32'(exp_q[match_idx]), 32'(rx_frame));
                exp_q.delete(match_idx);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the tests finished");
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        arst_n    = 1'b0;
        reg_wr    = '0;
        reg_raddr = '0;
        board_id  = 4'hA;
        for (int a = 0; a < `QLA_NUM_AXES; a++) begin
            cur_fb[a]    = '0;
            cmd_model[a] = '0;
        end
        repeat (5) @(posedge sysclk);
        #1;
        arst_n = 1'b1;

        // 1. reset values
        check_val("pwr_enable", 32'(1'b0), 32'(pwr_enable));
        check_val("amp_enable", 32'(4'h0), 32'(amp_enable));
        check_val("dac_csel", 32'(1'b1), 32'(dac_csel));
        check_val("dac_sclk", 32'(1'b0), 32'(dac_sclk));
        reg_read_check(board_addr(`QLA_OFF_STATUS), expected_status(board_id, '0, 1'b0, '0),
                       "status");
        for (int a = 0; a < `QLA_NUM_AXES; a++) begin
            reg_read_check(axis_addr(a, `QLA_OFF_DAC_CTRL), '0, "dac_readback");
        end

        // 2. one command and one frame per axis
        for (int a = 0; a < `QLA_NUM_AXES; a++) begin
            dac_write(a, cur_t'($random(seed)));
            reg_read_check(axis_addr(a, `QLA_OFF_DAC_CTRL), reg_data_t'(cmd_model[a]),
                           "dac_readback");
            wait_frames_done();
        end
        wait_cycles(FRAME_CYCLES);              // any extra frame trips the checker

        // 3. burst with an overwrite before axis 2 is sent
        for (int a = 0; a < `QLA_NUM_AXES; a++) begin
            dac_write(a, cur_t'($random(seed)));
        end
        dac_write(2, cur_t'($random(seed)));
        wait_frames_done();
        wait_cycles(FRAME_CYCLES);

        // 4. enable all then over-current on axis 1
        dac_write(1, 16'h1000);
        wait_frames_done();
        reg_write(board_addr(`QLA_OFF_CTRL), 32'h0000_010F);
        check_val("pwr_enable", 32'(1'b1), 32'(pwr_enable));
        check_val("amp_enable", 32'(4'hF), 32'(amp_enable));
        reg_read_check(board_addr(`QLA_OFF_CTRL), 32'h0000_010F, "ctrl_readback");
        cur_fb[1] = 16'h2001;
        for (int a = 0; a < `QLA_NUM_AXES; a++) begin
            trip_exp[a] = expected_trip(cur_fb[a], cmd_model[a]);
        end
        wait_n = 0;
        while (amp_enable[1] && wait_n < `QLA_SAFETY_COUNT + 4) begin
            wait_cycles(1);
            wait_n = wait_n + 1;
        end
        if (amp_enable[1]) begin
            abort_run("axis 1 did not trip within the persistence bound");
        end
        if (wait_n < `QLA_SAFETY_COUNT) begin
            abort_run($sformatf("axis 1 tripped after only %0d cycles", wait_n));
        end
        check_val("amp_enable", 32'(4'hF & ~trip_exp), 32'(amp_enable));
        reg_read_check(board_addr(`QLA_OFF_STATUS),
                       expected_status(board_id, trip_exp, 1'b1, 4'hF), "status");

        // 5. dip restarts the count on axis 2
        dac_write(2, 16'h0800);
        wait_frames_done();
        cur_fb[2] = 16'h1001;
        wait_cycles(`QLA_SAFETY_COUNT - 1);     // one short of a trip
        cur_fb[2] = 16'h1000;                   // equal to the limit so not over
        wait_cycles(1);
        cur_fb[2] = 16'h1001;
        wait_cycles(`QLA_SAFETY_COUNT - 1);
        cur_fb[2] = '0;
        wait_cycles(1);
        check_val("amp_enable", 32'(4'hF & ~trip_exp), 32'(amp_enable));
        reg_read_check(board_addr(`QLA_OFF_STATUS),
                       expected_status(board_id, trip_exp, 1'b1, 4'hF), "status");

        // clear axis 1 with the fault gone
        cur_fb[1] = '0;
        reg_write(board_addr(`QLA_OFF_CTRL), 32'h0002_010F);
        wait_cycles(1);                         // clear pulse then latch drops
        check_val("amp_enable", 32'(4'hF), 32'(amp_enable));
        reg_read_check(board_addr(`QLA_OFF_STATUS),
                       expected_status(board_id, '0, 1'b1, 4'hF), "status");

        // feedback readback too short to ever trip
        for (int a = 0; a < `QLA_NUM_AXES; a++) begin
            cur_fb[a] = cur_t'($random(seed));
            reg_read_check(axis_addr(a, `QLA_OFF_ADC_DATA), reg_data_t'(cur_fb[a]),
                           "adc_readback");
            cur_fb[a] = '0;
        end
        reg_read_check(reg_addr_t'(16'h0052), '0, "unmapped_read");
        wait_cycles(4);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
hdl/qla_pkg.sv
hdl/safety_check.sv
hdl/board_regs.sv
hdl/ctrl_dac.sv
hdl/qla_axis_top.sv
bench/tb_qla.sv

// ==== Makefile ====
# Verilator build and run for the qla motor channel testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_qla
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

# exit status of the simulation is the test result
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
